// ==== graphics_golden.txt ====
# tags: command <opcode hex> | operand <byte hex> <repeat> | swap
# wait <frames> | probe <x> <y> <expected color hex>
command 12
operand 00 5
operand 10 1
operand 10 1
operand 00 1
operand 33 64
swap
command 11
operand 03 1
operand A0 2
operand 60 1
wait 2
probe 0 0 2AB
probe 7 3 2AB
probe 15 7 2AB
command 11
operand 01 1
operand 50 1
operand 40 1
operand E0 1
command 11
operand 02 1
operand F0 1
operand 00 1
operand 20 1
command 12
operand 00 5
operand 10 1
operand 04 1
operand 00 1
operand 1B 32
wait 1
probe 0 0 2AB
probe 1 0 2AB
swap
wait 2
probe 0 0 000
probe 1 0 157
probe 2 0 3C1
probe 3 0 2AB
probe 15 7 2AB
command 11
operand 05 1
operand 30 1
operand E0 1
operand 00 1
command 11
operand 06 1
operand C0 1
operand 20 1
operand 80 1
command 12
operand 00 3
operand 01 1
operand 00 1
operand 08 1
operand 01 1
operand 05 1
operand A5 1
command 12
operand 00 1
operand 0C 1
operand 00 1
operand 04 1
operand 00 1
operand 06 1
operand 10 1
operand 00 1
operand 12 6
swap
wait 2
probe 0 1 30C
probe 1 1 0F8
probe 7 1 30C
probe 8 1 2AB
probe 0 0 2AB
probe 11 4 2AB
probe 12 4 157
probe 13 4 3C1
probe 15 4 3C1
probe 0 5 2AB
probe 1 5 2AB
probe 12 5 157
probe 15 5 3C1

// ==== vlog.f ====
graphics_pkg.sv
command_decoder.sv
sprite_engine.sv
display_buffers.sv
color_palette.sv
display_timing.sv
graphics.sv
graphics_properties.sv
graphics_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module graphics_tb \
		-f vlog.f -o graphics_sim
	./obj_dir/graphics_sim | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== graphics_tb.sv ====
// Testbench for the graphics top level driven by the golden command file
`timescale 1ns/1ps

module graphics_tb;
    import graphics_pkg::*;

    localparam int DISPLAY_WIDTH  = 16;
    localparam int DISPLAY_HEIGHT = 8;
    localparam int H_BLANK        = 8;
    localparam int V_BLANK        = 2;
    localparam int FRAME_PIXELS   = DISPLAY_WIDTH * DISPLAY_HEIGHT;
    localparam int FRAME_CYCLES   = (DISPLAY_WIDTH + H_BLANK) * (DISPLAY_HEIGHT + V_BLANK);
    localparam int GAP_BUDGET     = 30;
    localparam string GOLDEN_FILE = "graphics_golden.txt";

    logic                   display_clock_in;
    logic                   display_reset_n_in;
    opcode_e                op_code;
    logic                   op_code_valid;
    logic [7:0]             operand;
    logic                   operand_valid;
    logic                   display_hsync;
    logic                   display_vsync;
    logic                   display_data_enable;
    logic [Y_WIDTH-1:0]     display_y;
    logic [CB_WIDTH-1:0]    display_cb;
    logic [CR_WIDTH-1:0]    display_cr;

    logic [COLOR_WIDTH-1:0] pixels [FRAME_PIXELS];
    logic [COLOR_WIDTH-1:0] last_frame [FRAME_PIXELS];
    int                     pixel_count;
    int                     line_count;
    int                     hsync_count;
    int                     frames_done;
    longint                 cycle;
    longint                 last_vsync_cycle;
    logic                   de_last;
    logic                   vsync_last;
    logic                   hsync_last;
    logic [31:0]            lfsr_state;
    logic                   command_open;
    longint                 budget;
    int                     color_errors;
    int                     count_errors;
    int                     other_errors;

    graphics #(
        .DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
        .H_BLANK(H_BLANK), .V_BLANK(V_BLANK)
    ) dut0 (
        .display_clock_in, .display_reset_n_in,
        .op_code, .op_code_valid, .operand, .operand_valid,
        .display_hsync, .display_vsync, .display_data_enable,
        .display_y, .display_cb, .display_cr
    );

    always #20 display_clock_in = ~display_clock_in;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic idle_gap();
        int cycles;
        cycles = 10;
        for (int i = 0; i < 4; i++) begin
            cycles = cycles + (int'(lfsr_state[0]) << i);
            lfsr_state = lfsr_step(lfsr_state);
        end
        repeat (cycles) @(posedge display_clock_in);
    endtask

    task automatic check_color(input string name, input logic [COLOR_WIDTH-1:0] got,
                               input logic [COLOR_WIDTH-1:0] expected);
        if (got !== expected) begin
            color_errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            count_errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic end_command();
        if (command_open) begin
            @(posedge display_clock_in);
            op_code_valid <= 1'b0;
            command_open = 1'b0;
            idle_gap();
        end
    endtask

    task automatic start_command(input logic [7:0] code);
        end_command();
        @(posedge display_clock_in);
        op_code       <= opcode_e'(code);
        op_code_valid <= 1'b1;
        command_open = 1'b1;
        idle_gap();
    endtask

    task automatic send_operand(input logic [7:0] value);
        @(posedge display_clock_in);
        operand       <= value;
        operand_valid <= 1'b1;
        @(posedge display_clock_in);
        operand_valid <= 1'b0;
        idle_gap();
    endtask

    task automatic wait_frames(input int frames);
        int target;
        target = frames_done + frames;
        while (frames_done < target)
            @(posedge display_clock_in);
    endtask

    // Walks the golden file; without execute it only sums the time budget
    task automatic run_golden(input bit execute);
        int               fd;
        int               code;
        int               a;
        int               b;
        int               c;
        logic [127:0]     tag;
        logic [8*128-1:0] rest;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the golden file");
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "command") begin
                code = $fscanf(fd, "%h", a);
                if (execute)
                    start_command(a[7:0]);
                else
                    budget += 2 * GAP_BUDGET;
            end else if (tag == "operand") begin
                code = $fscanf(fd, "%h %d", a, b);
                for (int i = 0; i < b && execute; i++)
                    send_operand(a[7:0]);
                if (!execute)
                    budget += b * GAP_BUDGET;
            end else if (tag == "swap") begin
                if (execute) begin
                    start_command(OP_SWITCH_BUFFER);
                    end_command();
                end else begin
                    budget += 3 * GAP_BUDGET;
                end
            end else if (tag == "wait") begin
                code = $fscanf(fd, "%d", a);
                if (execute) begin
                    end_command();
                    wait_frames(a);
                end else begin
                    budget += (a + 1) * FRAME_CYCLES;
                end
            end else if (tag == "probe") begin
                code = $fscanf(fd, "%d %d %h", a, b, c);
                if (execute)
                    check_color($sformatf("pixel (%0d,%0d)", a, b),
                                last_frame[b * DISPLAY_WIDTH + a], c[COLOR_WIDTH-1:0]);
            end else begin
                other_errors++;
                $display("Unknown tag in the golden file: %0s", tag);
            end
        end
        $fclose(fd);
        if (execute)
            end_command();
    endtask

    // Frame capture and raster checks, one frame per vsync
    always @(posedge display_clock_in) begin
        if (display_reset_n_in) begin
            if (display_data_enable) begin
                if (pixel_count < FRAME_PIXELS)
                    pixels[pixel_count] = {display_y, display_cb, display_cr};
                pixel_count++;
                if (!de_last)
                    line_count++;
            end
            if (display_hsync && !hsync_last)
                hsync_count++;
            if (display_vsync && !vsync_last) begin
                check_count("pixels per frame", pixel_count, FRAME_PIXELS);
                check_count("lines per frame", line_count, DISPLAY_HEIGHT);
                if (frames_done > 0) begin
                    check_count("vsync period", int'(cycle - last_vsync_cycle), FRAME_CYCLES);
                    check_count("hsync pulses per frame", hsync_count,
                                DISPLAY_HEIGHT + V_BLANK);
                end
                last_frame       = pixels;
                last_vsync_cycle = cycle;
                pixel_count      = 0;
                line_count       = 0;
                hsync_count      = 0;
                frames_done++;
            end
            de_last    = display_data_enable;
            vsync_last = display_vsync;
            hsync_last = display_hsync;
        end
        cycle++;
    end

    initial begin
        display_clock_in   = 1'b0;
        display_reset_n_in = 1'b0;
        op_code            = OP_SWITCH_BUFFER;
        op_code_valid      = 1'b0;
        operand            = 8'h00;
        operand_valid      = 1'b0;
        pixel_count        = 0;
        line_count         = 0;
        hsync_count        = 0;
        frames_done        = 0;
        cycle              = 0;
        last_vsync_cycle   = 0;
        de_last            = 1'b0;
        vsync_last         = 1'b0;
        hsync_last         = 1'b0;
        lfsr_state         = 32'hdead;
        command_open       = 1'b0;
        budget             = 0;
        color_errors       = 0;
        count_errors       = 0;
        other_errors       = 0;
        run_golden(1'b0);
        budget += 4 * FRAME_CYCLES;
        fork
            begin
                #(budget * 40);
                $display("Timeout: the golden stimulus did not finish in time");
                $display(">>> FAIL");
                $finish;
            end
        join_none
        repeat (5) @(posedge display_clock_in);
        display_reset_n_in <= 1'b1;
        wait_frames(1);
        run_golden(1'b1);
        $display("Errors: color %0d, count %0d, other %0d",
                 color_errors, count_errors, other_errors);
        if (color_errors + count_errors + other_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== graphics_properties.sv ====
// Raster timing assertions bound to display_timing
`timescale 1ns/1ps

module graphics_properties #(
    parameter int DISPLAY_WIDTH  = 640,
    parameter int DISPLAY_HEIGHT = 400,
    parameter int H_BLANK        = 160,
    parameter int V_BLANK        = 45
) (
    input logic                                             display_clock_in,
    input logic                                             display_reset_n_in,
    input logic                                             display_hsync,
    input logic                                             display_data_enable,
    input logic                                             active,
    input logic [$clog2(DISPLAY_WIDTH+H_BLANK)-1:0]         h_count,
    input logic [$clog2(DISPLAY_HEIGHT+V_BLANK)-1:0]        v_count,
    input logic [$clog2(DISPLAY_WIDTH*DISPLAY_HEIGHT)-1:0] read_address
);

    no_enable_in_hsync: assert property (@(posedge display_clock_in)
        disable iff (!display_reset_n_in) !(display_data_enable && display_hsync))
        else $error("data enable high during hsync");

    // Pulse covers the first half of horizontal blanking
    hsync_width: assert property (@(posedge display_clock_in)
        disable iff (!display_reset_n_in)
        $fell(display_hsync) |-> $past(display_hsync, H_BLANK / 2)
                                 && !$past(display_hsync, H_BLANK / 2 + 1))
        else $error("hsync pulse width changed");

    // Address follows the raster position inside the active area
    address_in_range: assert property (@(posedge display_clock_in)
        disable iff (!display_reset_n_in)
        active |-> int'(read_address) == int'(v_count) * DISPLAY_WIDTH + int'(h_count))
        else $error("read address does not match the raster position");

endmodule

bind display_timing graphics_properties #(
    .DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
    .H_BLANK(H_BLANK), .V_BLANK(V_BLANK)
) timing_properties (
    .display_clock_in(display_clock_in), .display_reset_n_in(display_reset_n_in),
    .display_hsync(display_hsync), .display_data_enable(display_data_enable),
    .active(active), .h_count(h_count), .v_count(v_count),
    .read_address(read_address)
);

// ==== graphics.sv ====
// Graphics top level with decoder, sprite engine, frame buffers, palette and raster timing
`timescale 1ns/1ps

module graphics #(
    parameter int DISPLAY_WIDTH  = 640,
    parameter int DISPLAY_HEIGHT = 400,
    parameter int H_BLANK        = 160,
    parameter int V_BLANK        = 45
) (
    input  logic                              display_clock_in,
    input  logic                              display_reset_n_in,
    input  graphics_pkg::opcode_e             op_code,
    input  logic                              op_code_valid,
    input  logic [7:0]                        operand,
    input  logic                              operand_valid,
    output logic                              display_hsync,
    output logic                              display_vsync,
    output logic                              display_data_enable,
    output logic [graphics_pkg::Y_WIDTH-1:0]  display_y,
    output logic [graphics_pkg::CB_WIDTH-1:0] display_cb,
    output logic [graphics_pkg::CR_WIDTH-1:0] display_cr
);
    import graphics_pkg::*;

    localparam int ADDRESS_WIDTH = $clog2(DISPLAY_WIDTH * DISPLAY_HEIGHT);

    logic                     color_write;
    logic [INDEX_WIDTH-1:0]   color_index;
    logic [COLOR_WIDTH-1:0]   color_value;
    logic                     sprite_start;
    logic [9:0]               sprite_x;
    logic [9:0]               sprite_y;
    logic [9:0]               sprite_width;
    logic [4:0]               sprite_color_count;
    logic [INDEX_WIDTH-1:0]   sprite_palette_offset;
    logic                     sprite_data_valid;
    logic [7:0]               sprite_data;
    logic                     swap_request;
    logic                     pixel_write;
    logic [ADDRESS_WIDTH-1:0] pixel_address;
    logic [INDEX_WIDTH-1:0]   pixel_index;
    logic [ADDRESS_WIDTH-1:0] read_address;
    logic                     frame_start;
    logic [INDEX_WIDTH-1:0]   read_index;

    command_decoder command_decoder (
        .display_clock_in, .display_reset_n_in,
        .op_code, .op_code_valid, .operand, .operand_valid,
        .color_write, .color_index, .color_value,
        .sprite_start, .sprite_x, .sprite_y, .sprite_width,
        .sprite_color_count, .sprite_palette_offset,
        .sprite_data_valid, .sprite_data, .swap_request
    );

    sprite_engine #(.DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT)) sprite_engine (
        .display_clock_in, .display_reset_n_in,
        .sprite_start, .sprite_x, .sprite_y, .sprite_width,
        .sprite_color_count, .sprite_palette_offset,
        .sprite_data_valid, .sprite_data,
        .pixel_write, .pixel_address, .pixel_index
    );

    display_buffers #(.DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT)) display_buffers (
        .display_clock_in, .display_reset_n_in,
        .pixel_write, .pixel_address, .pixel_index,
        .read_address, .frame_start, .swap_request, .read_index
    );

    color_palette color_palette (
        .display_clock_in, .display_reset_n_in,
        .color_write, .color_index, .color_value, .read_index,
        .display_y, .display_cb, .display_cr
    );

    display_timing #(
        .DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
        .H_BLANK(H_BLANK), .V_BLANK(V_BLANK)
    ) display_timing (
        .display_clock_in, .display_reset_n_in,
        .read_address, .frame_start,
        .display_hsync, .display_vsync, .display_data_enable
    );

endmodule

// ==== display_timing.sv ====
// Raster timing with sync, data enable, frame start and front-buffer read address
`timescale 1ns/1ps

module display_timing #(
    parameter int DISPLAY_WIDTH  = 640,
    parameter int DISPLAY_HEIGHT = 400,
    parameter int H_BLANK        = 160,
    parameter int V_BLANK        = 45
) (
    input  logic                                             display_clock_in,
    input  logic                                             display_reset_n_in,
    output logic [$clog2(DISPLAY_WIDTH*DISPLAY_HEIGHT)-1:0] read_address,
    output logic                                             frame_start,
    output logic                                             display_hsync,
    output logic                                             display_vsync,
    output logic                                             display_data_enable
);
    localparam int H_TOTAL       = DISPLAY_WIDTH + H_BLANK;
    localparam int V_TOTAL       = DISPLAY_HEIGHT + V_BLANK;
    localparam int H_COUNT_WIDTH = $clog2(H_TOTAL);
    localparam int V_COUNT_WIDTH = $clog2(V_TOTAL);

    logic [H_COUNT_WIDTH-1:0] h_count;
    logic [V_COUNT_WIDTH-1:0] v_count;
    logic                     line_end;
    logic                     frame_end;
    logic                     active;
    logic                     hsync;
    logic                     vsync;
    // {hsync, vsync, data enable} matched to buffer and palette latency
    logic [2:0]               delay_0;
    logic [2:0]               delay_1;

    assign line_end  = h_count == H_TOTAL - 1;
    assign frame_end = line_end && v_count == V_TOTAL - 1;
    assign active    = h_count < DISPLAY_WIDTH && v_count < DISPLAY_HEIGHT;
    assign hsync     = h_count >= DISPLAY_WIDTH && h_count < DISPLAY_WIDTH + H_BLANK / 2;
    assign vsync     = v_count == DISPLAY_HEIGHT;

    // Counters leave reset on the last position so a frame starts right away
    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            h_count      <= H_COUNT_WIDTH'(H_TOTAL - 1);
            v_count      <= V_COUNT_WIDTH'(V_TOTAL - 1);
            read_address <= '0;
            frame_start  <= 1'b0;
            delay_0      <= '0;
            delay_1      <= '0;
        end else begin
            frame_start <= frame_end;
            delay_0     <= {hsync, vsync, active};
            delay_1     <= delay_0;
            if (line_end) begin
                h_count <= '0;
                v_count <= frame_end ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
            if (frame_end)
                read_address <= '0;
            else if (active)
                read_address <= read_address + 1'b1;
        end
    end

    assign {display_hsync, display_vsync, display_data_enable} = delay_1;

endmodule

// ==== color_palette.sv ====
// YCbCr palette register file with registered lookup
`timescale 1ns/1ps

module color_palette (
    input  logic                                 display_clock_in,
    input  logic                                 display_reset_n_in,
    input  logic                                 color_write,
    input  logic [graphics_pkg::INDEX_WIDTH-1:0] color_index,
    input  logic [graphics_pkg::COLOR_WIDTH-1:0] color_value,
    input  logic [graphics_pkg::INDEX_WIDTH-1:0] read_index,
    output logic [graphics_pkg::Y_WIDTH-1:0]     display_y,
    output logic [graphics_pkg::CB_WIDTH-1:0]    display_cb,
    output logic [graphics_pkg::CR_WIDTH-1:0]    display_cr
);
    import graphics_pkg::*;

    logic [COLOR_WIDTH-1:0] palette [PALETTE_ENTRIES];
    logic [COLOR_WIDTH-1:0] color;

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            for (int i = 0; i < PALETTE_ENTRIES; i++) begin
                palette[i] <= '0;
            end
        end else if (color_write) begin
            palette[color_index] <= color_value;
        end
    end

    // Second cycle of the pixel pipeline
    always_ff @(posedge display_clock_in) begin
        color <= palette[read_index];
    end

    assign display_y  = color[COLOR_WIDTH-1 -: Y_WIDTH];
    assign display_cb = color[CB_WIDTH+CR_WIDTH-1 -: CB_WIDTH];
    assign display_cr = color[CR_WIDTH-1:0];

endmodule

// ==== display_buffers.sv ====
// Double-buffered frame store of palette indices with frame-synchronous swap
`timescale 1ns/1ps

module display_buffers #(
    parameter int DISPLAY_WIDTH  = 640,
    parameter int DISPLAY_HEIGHT = 400
) (
    input  logic                                             display_clock_in,
    input  logic                                             display_reset_n_in,
    input  logic                                             pixel_write,
    input  logic [$clog2(DISPLAY_WIDTH*DISPLAY_HEIGHT)-1:0] pixel_address,
    input  logic [graphics_pkg::INDEX_WIDTH-1:0]             pixel_index,
    input  logic [$clog2(DISPLAY_WIDTH*DISPLAY_HEIGHT)-1:0] read_address,
    input  logic                                             frame_start,
    input  logic                                             swap_request,
    output logic [graphics_pkg::INDEX_WIDTH-1:0]             read_index
);
    import graphics_pkg::*;

    localparam int DEPTH = DISPLAY_WIDTH * DISPLAY_HEIGHT;

    logic [INDEX_WIDTH-1:0] frame_store_0 [DEPTH];
    logic [INDEX_WIDTH-1:0] frame_store_1 [DEPTH];
    logic                   buffer_select;
    logic                   swap_pending;
    logic                   swap_now;
    logic                   read_select;

    // Front buffer is frame_store_1 when buffer_select is set
    assign swap_now    = frame_start && swap_pending;
    // New front already serves the first pixel of the frame
    assign read_select = buffer_select ^ swap_now;

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            buffer_select <= 1'b0;
            swap_pending  <= 1'b0;
        end else if (swap_now) begin
            buffer_select <= ~buffer_select;
            swap_pending  <= swap_request;
        end else if (swap_request) begin
            swap_pending <= 1'b1;
        end
    end

    always_ff @(posedge display_clock_in) begin
        if (pixel_write && buffer_select)
            frame_store_0[pixel_address] <= pixel_index;
        if (pixel_write && !buffer_select)
            frame_store_1[pixel_address] <= pixel_index;
        read_index <= read_select ? frame_store_1[read_address] : frame_store_0[read_address];
    end

endmodule

// ==== sprite_engine.sv ====
// Sprite engine unpacking 1, 2 or 4 bit pixels into clipped frame-store writes
`timescale 1ns/1ps

module sprite_engine #(
    parameter int DISPLAY_WIDTH  = 640,
    parameter int DISPLAY_HEIGHT = 400
) (
    input  logic                                                 display_clock_in,
    input  logic                                                 display_reset_n_in,
    input  logic                                                 sprite_start,
    input  logic [9:0]                                           sprite_x,
    input  logic [9:0]                                           sprite_y,
    input  logic [9:0]                                           sprite_width,
    input  logic [4:0]                                           sprite_color_count,
    input  logic [graphics_pkg::INDEX_WIDTH-1:0]                 sprite_palette_offset,
    input  logic                                                 sprite_data_valid,
    input  logic [7:0]                                           sprite_data,
    output logic                                                 pixel_write,
    output logic [$clog2(DISPLAY_WIDTH*DISPLAY_HEIGHT)-1:0]     pixel_address,
    output logic [graphics_pkg::INDEX_WIDTH-1:0]                 pixel_index
);
    import graphics_pkg::*;

    localparam int ADDRESS_WIDTH = $clog2(DISPLAY_WIDTH * DISPLAY_HEIGHT);

    logic [9:0]             origin_x;
    logic [9:0]             width;
    logic [4:0]             color_count;
    logic [INDEX_WIDTH-1:0] palette_offset;
    logic [10:0]            cursor_x;
    logic [10:0]            cursor_y;
    logic [9:0]             column;
    logic [7:0]             shift_data;
    logic [3:0]             pixels_left;
    logic [2:0]             bits_per_pixel;
    logic [INDEX_WIDTH-1:0] pixel_value;
    logic                   row_end;

    // MSB-first field of the current byte
    always_comb begin
        case (color_count)
            5'd1: begin
                bits_per_pixel = 3'd1;
                pixel_value    = INDEX_WIDTH'(shift_data[7]);
            end
            5'd4: begin
                bits_per_pixel = 3'd2;
                pixel_value    = INDEX_WIDTH'(shift_data[7:6]);
            end
            default: begin
                bits_per_pixel = 3'd4;
                pixel_value    = shift_data[7 -: INDEX_WIDTH];
            end
        endcase
    end

    assign row_end       = column == width - 10'd1;
    assign pixel_index   = pixel_value + palette_offset;
    assign pixel_write   = pixels_left != '0 && cursor_x < DISPLAY_WIDTH
                           && cursor_y < DISPLAY_HEIGHT;
    assign pixel_address = ADDRESS_WIDTH'(cursor_y * DISPLAY_WIDTH + cursor_x);

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            pixels_left <= '0;
        end else if (sprite_data_valid) begin
            pixels_left <= 4'(8 / bits_per_pixel);
        end else if (pixels_left != '0) begin
            pixels_left <= pixels_left - 4'd1;
        end
    end

    always_ff @(posedge display_clock_in) begin
        if (sprite_start) begin
            origin_x       <= sprite_x;
            width          <= sprite_width;
            color_count    <= sprite_color_count;
            palette_offset <= sprite_palette_offset;
            cursor_x       <= {1'b0, sprite_x};
            cursor_y       <= {1'b0, sprite_y};
            column         <= '0;
        end else if (pixels_left != '0) begin
            if (row_end) begin
                column   <= '0;
                cursor_x <= {1'b0, origin_x};
                cursor_y <= cursor_y + 11'd1;
            end else begin
                column   <= column + 10'd1;
                cursor_x <= cursor_x + 11'd1;
            end
        end
        if (sprite_data_valid)
            shift_data <= sprite_data;
        else if (pixels_left != '0)
            shift_data <= shift_data << bits_per_pixel;
    end

endmodule

// ==== command_decoder.sv ====
// Command decoder FSM issuing palette, sprite and buffer swap strobes
`timescale 1ns/1ps

module command_decoder (
    input  logic                                 display_clock_in,
    input  logic                                 display_reset_n_in,
    input  graphics_pkg::opcode_e                op_code,
    input  logic                                 op_code_valid,
    input  logic [7:0]                           operand,
    input  logic                                 operand_valid,
    output logic                                 color_write,
    output logic [graphics_pkg::INDEX_WIDTH-1:0] color_index,
    output logic [graphics_pkg::COLOR_WIDTH-1:0] color_value,
    output logic                                 sprite_start,
    output logic [9:0]                           sprite_x,
    output logic [9:0]                           sprite_y,
    output logic [9:0]                           sprite_width,
    output logic [4:0]                           sprite_color_count,
    output logic [graphics_pkg::INDEX_WIDTH-1:0] sprite_palette_offset,
    output logic                                 sprite_data_valid,
    output logic [7:0]                           sprite_data,
    output logic                                 swap_request
);
    import graphics_pkg::*;

    decoder_state_e state;
    logic [2:0]     operand_count;
    logic           color_byte;
    logic           header_byte;

    assign color_byte  = operand_valid && state == DEC_COLOR;
    assign header_byte = operand_valid && state == DEC_SPRITE_HEADER;

    always_ff @(posedge display_clock_in) begin
        if (!display_reset_n_in) begin
            state             <= DEC_IDLE;
            operand_count     <= '0;
            color_write       <= 1'b0;
            sprite_start      <= 1'b0;
            sprite_data_valid <= 1'b0;
            swap_request      <= 1'b0;
        end else begin
            color_write       <= 1'b0;
            sprite_start      <= 1'b0;
            sprite_data_valid <= 1'b0;
            swap_request      <= 1'b0;
            if (!op_code_valid) begin
                state         <= DEC_IDLE;
                operand_count <= '0;
            end else begin
                case (state)
                    DEC_IDLE: begin
                        case (op_code)
                            OP_ASSIGN_COLOR: state <= DEC_COLOR;
                            OP_DRAW_SPRITE:  state <= DEC_SPRITE_HEADER;
                            OP_SWITCH_BUFFER: begin
                                swap_request <= 1'b1;
                                state        <= DEC_DONE;
                            end
                            default: state <= DEC_DONE;
                        endcase
                    end
                    DEC_COLOR: begin
                        if (operand_valid) begin
                            operand_count <= operand_count + 3'd1;
                            if (operand_count == 3'd3) begin
                                color_write <= 1'b1;
                                state       <= DEC_DONE;
                            end
                        end
                    end
                    DEC_SPRITE_HEADER: begin
                        if (operand_valid) begin
                            operand_count <= operand_count + 3'd1;
                            if (operand_count == 3'd7) begin
                                sprite_start <= 1'b1;
                                state        <= DEC_SPRITE_DATA;
                            end
                        end
                    end
                    DEC_SPRITE_DATA: sprite_data_valid <= operand_valid;
                    // Waits here until op_code_valid falls
                    default: state <= DEC_DONE;
                endcase
            end
        end
    end

    // Field capture
    always_ff @(posedge display_clock_in) begin
        if (color_byte) begin
            case (operand_count)
                3'd0: color_index <= operand[INDEX_WIDTH-1:0];
                3'd1: color_value[COLOR_WIDTH-1 -: Y_WIDTH] <= operand[7 -: Y_WIDTH];
                3'd2: color_value[CB_WIDTH+CR_WIDTH-1 -: CB_WIDTH] <= operand[7 -: CB_WIDTH];
                default: color_value[CR_WIDTH-1:0] <= operand[7 -: CR_WIDTH];
            endcase
        end
        if (header_byte) begin
            case (operand_count)
                3'd0: sprite_x[9:8] <= operand[1:0];
                3'd1: sprite_x[7:0] <= operand;
                3'd2: sprite_y[9:8] <= operand[1:0];
                3'd3: sprite_y[7:0] <= operand;
                3'd4: sprite_width[9:8] <= operand[1:0];
                3'd5: sprite_width[7:0] <= operand;
                3'd6: sprite_color_count <= operand[4:0];
                default: sprite_palette_offset <= operand[INDEX_WIDTH-1:0];
            endcase
        end
        if (operand_valid && state == DEC_SPRITE_DATA)
            sprite_data <= operand;
    end

endmodule

// ==== graphics_pkg.sv ====
// Command opcodes, decoder states and palette color widths
package graphics_pkg;

    // Command bytes
    typedef enum logic [7:0] {
        OP_ASSIGN_COLOR  = 8'h11,
        OP_DRAW_SPRITE   = 8'h12,
        OP_SWITCH_BUFFER = 8'h14
    } opcode_e;

    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_COLOR,
        DEC_SPRITE_HEADER,
        DEC_SPRITE_DATA,
        DEC_DONE
    } decoder_state_e;

    // Palette slots and index width
    localparam int PALETTE_ENTRIES = 16;
    localparam int INDEX_WIDTH     = $clog2(PALETTE_ENTRIES);

    // YCbCr field widths, Y in the top bits
    localparam int Y_WIDTH     = 4;
    localparam int CB_WIDTH    = 3;
    localparam int CR_WIDTH    = 3;
    localparam int COLOR_WIDTH = Y_WIDTH + CB_WIDTH + CR_WIDTH;

endpackage
